//--- source/cache_pkg.sv
`default_nettype none

package cache_pkg;

    // cache geometry
    localparam int addr_w        = 32;
    localparam int data_w        = 32;
    localparam int byte_offset_w = $clog2(data_w / 8);
    localparam int word_offset_w = 2;  // also the burst counter width
    localparam int index_w       = 4;  // 16 lines, direct mapped
    localparam int tag_w         = addr_w - index_w - word_offset_w - byte_offset_w;
    localparam int line_addr_w   = tag_w + index_w;

    // one burst per line, back end as wide as the front end
    localparam logic [7:0] burst_len = 8'(2 ** word_offset_w - 1);
    localparam int         axi_id_w  = 1;

    // fixed AXI AR fields
    localparam logic [2:0] axi_size_val   = 3'(byte_offset_w);
    localparam logic [1:0] axi_burst_incr = 2'b01;
    localparam logic [3:0] axi_cache_val  = 4'b0011;  // bufferable, modifiable
    localparam logic [2:0] axi_prot_val   = 3'd0;
    localparam logic [3:0] axi_qos_val    = 4'd0;
    localparam logic [0:0] axi_lock_val   = 1'b0;

    // one byte address, seen as cache fields or as line number
    typedef union packed {
        struct packed {
            logic [tag_w-1:0]         tag;
            logic [index_w-1:0]       index;
            logic [word_offset_w-1:0] word_offset;
            logic [byte_offset_w-1:0] byte_offset;
        } fields;
        struct packed {
            logic [line_addr_w-1:0]                 line;
            logic [word_offset_w+byte_offset_w-1:0] offset;  // byte within the line
        } line_view;
    } cache_addr_u;

endpackage

`default_nettype wire

//--- source/cache_if.sv
`default_nettype none

// refill path from the AXI engine into the line storage
interface line_fill_if;

    logic                                replace;     // refill in progress
    logic                                read_valid;  // one strobe per accepted beat
    logic [cache_pkg::word_offset_w-1:0] read_addr;   // word within the line
    logic [cache_pkg::data_w-1:0]        read_rdata;

    modport channel (
        output replace,
        output read_valid,
        output read_addr,
        output read_rdata
    );

    modport memory (
        input replace,
        input read_valid,
        input read_addr,
        input read_rdata
    );

endinterface

// lookup of the held front-end request
interface lookup_if;

    logic [cache_pkg::index_w-1:0]       index;
    logic [cache_pkg::tag_w-1:0]         tag;
    logic [cache_pkg::word_offset_w-1:0] word_offset;
    logic                                hit;
    logic [cache_pkg::data_w-1:0]        rdata;

    modport control (
        output index,
        output tag,
        output word_offset,
        input  hit,
        input  rdata
    );

    modport memory (
        input  index,
        input  tag,
        input  word_offset,
        output hit,
        output rdata
    );

endinterface

`default_nettype wire

//--- source/cache_control.sv
`default_nettype none

module cache_control
(
    input  wire                                  clk,
    input  wire                                  reset,
    // front end, address held until fe_ready
    input  wire                                  fe_valid,
    input  wire  [cache_pkg::addr_w-1:0]         fe_addr,
    output logic [cache_pkg::data_w-1:0]         fe_rdata,
    output logic                                 fe_ready,
    // refill request towards the AXI engine
    output logic                                 replace_valid,
    output logic [cache_pkg::line_addr_w-1:0]    replace_addr,
    input  wire                                  replace,
    lookup_if.control                            lookup
);

    cache_pkg::cache_addr_u req;
    logic                   miss;
    logic                   requested;  // refill already asked for this miss

    assign req = fe_addr;

    // field view drives the tag compare and word select
    assign lookup.index       = req.fields.index;
    assign lookup.tag         = req.fields.tag;
    assign lookup.word_offset = req.fields.word_offset;

    // line view is the burst base
    assign replace_addr = req.line_view.line;

    assign miss = fe_valid & ~lookup.hit;

    // hit answer, only while the line storage is not being refilled
    always_comb
    begin
        fe_ready = fe_valid & lookup.hit & ~replace;
        fe_rdata = lookup.rdata;
    end

    // one pulse per miss
    assign replace_valid = miss & ~replace & ~requested;

    // set with the pulse, dropped in the cycle replace goes low again;
    // replace is already high in the cycle after the pulse, so
    // requested & ~replace only happens at the end of the refill
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            requested <= 1'b0;
        end
        else if (replace_valid)
        begin
            requested <= 1'b1;
        end
        else if (requested && !replace)
        begin
            requested <= 1'b0;  // line valid is set on this same edge
        end
    end

endmodule

`default_nettype wire

//--- source/cache_memory.sv
`default_nettype none

module cache_memory
(
    input  wire         clk,
    input  wire         reset,
    lookup_if.memory    lookup,
    line_fill_if.memory fill
);

    localparam int lines = 2 ** cache_pkg::index_w;
    localparam int words = 2 ** cache_pkg::word_offset_w;

    logic [cache_pkg::data_w-1:0] data_mem [lines][words];
    logic [cache_pkg::tag_w-1:0]  tag_mem  [lines];
    logic [lines-1:0]             valid;
    logic                         replace_q;
    logic                         replace_fall;

    // refill done, the line becomes usable on this edge
    assign replace_fall = replace_q & ~fill.replace;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            replace_q <= 1'b0;
            valid     <= '0;
        end
        else
        begin
            replace_q <= fill.replace;
            if (fill.replace)
            begin
                valid[lookup.index] <= 1'b0;  // partly written line
            end
            else if (replace_fall)
            begin
                valid[lookup.index] <= 1'b1;
            end
        end
    end

    // payload storage, written beat by beat at the held index
    always_ff @(posedge clk)
    begin
        if (fill.replace && fill.read_valid)
        begin
            data_mem[lookup.index][fill.read_addr] <= fill.read_rdata;
        end
        if (replace_fall)
        begin
            tag_mem[lookup.index] <= lookup.tag;
        end
    end

    // lookup
    always_comb
    begin
        lookup.hit   = valid[lookup.index] && (tag_mem[lookup.index] == lookup.tag);
        lookup.rdata = data_mem[lookup.index][lookup.word_offset];
    end

endmodule

`default_nettype wire

//--- source/read_channel_axi.sv
`default_nettype none

module read_channel_axi
#(
    parameter logic [cache_pkg::axi_id_w-1:0] axi_id = '0
)
(
    input  wire                                  clk,
    input  wire                                  reset,
    // refill request from the control
    input  wire                                  replace_valid,
    input  wire  [cache_pkg::line_addr_w-1:0]    replace_addr,
    output logic                                 replace,
    line_fill_if.channel                         fill,
    // AXI read address
    output logic [cache_pkg::addr_w-1:0]         axi_araddr,
    output logic [7:0]                           axi_arlen,
    output logic [2:0]                           axi_arsize,
    output logic [1:0]                           axi_arburst,
    output logic [0:0]                           axi_arlock,
    output logic [3:0]                           axi_arcache,
    output logic [2:0]                           axi_arprot,
    output logic [3:0]                           axi_arqos,
    output logic [cache_pkg::axi_id_w-1:0]       axi_arid,
    output logic                                 axi_arvalid,
    input  wire                                  axi_arready,
    // AXI read data
    input  wire                                  axi_rvalid,
    input  wire  [cache_pkg::data_w-1:0]         axi_rdata,
    input  wire  [1:0]                           axi_rresp,
    input  wire                                  axi_rlast,
    output logic                                 axi_rready
);

    localparam logic [1:0] idle_st    = 2'd0;
    localparam logic [1:0] request_st = 2'd1;
    localparam logic [1:0] load_st    = 2'd2;
    localparam logic [1:0] end_st     = 2'd3;

    logic [1:0]                          state;
    logic [cache_pkg::word_offset_w-1:0] read_addr;
    logic                                slave_error;  // sticky over the whole burst
    logic                                beat;

    // fixed request fields
    assign axi_arid    = axi_id;
    assign axi_arlen   = cache_pkg::burst_len;
    assign axi_arsize  = cache_pkg::axi_size_val;
    assign axi_arburst = cache_pkg::axi_burst_incr;
    assign axi_arlock  = cache_pkg::axi_lock_val;
    assign axi_arcache = cache_pkg::axi_cache_val;
    assign axi_arprot  = cache_pkg::axi_prot_val;
    assign axi_arqos   = cache_pkg::axi_qos_val;

    // line aligned burst base
    assign axi_araddr = {replace_addr,
                         {(cache_pkg::word_offset_w + cache_pkg::byte_offset_w){1'b0}}};

    assign beat = axi_rvalid & axi_rready;

    // beats go straight into the line
    assign fill.replace    = replace;
    assign fill.read_valid = beat;
    assign fill.read_addr  = read_addr;
    assign fill.read_rdata = axi_rdata;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state       <= idle_st;
            read_addr   <= '0;
            slave_error <= 1'b0;
        end
        else
        begin
            case (state)
                idle_st:
                begin
                    slave_error <= 1'b0;
                    read_addr   <= '0;
                    if (replace_valid)
                    begin
                        state <= request_st;
                    end
                end
                request_st:
                begin
                    slave_error <= 1'b0;  // fresh start, also on a retry
                    read_addr   <= '0;
                    if (axi_arready)
                    begin
                        state <= load_st;
                    end
                end
                load_st:
                begin
                    if (beat)
                    begin
                        // an error cannot cut the burst short, remember it
                        if (axi_rresp != 2'b00)
                        begin
                            slave_error <= 1'b1;
                        end
                        if (axi_rlast)
                        begin
                            state <= end_st;  // keep read_addr on the last word
                        end
                        else
                        begin
                            read_addr <= read_addr + 1'b1;
                        end
                    end
                end
                default:
                begin
                    // end of burst, retry the whole line after any error
                    if (slave_error)
                    begin
                        state <= request_st;
                    end
                    else
                    begin
                        state <= idle_st;
                    end
                end
            endcase
        end
    end

    always_comb
    begin
        axi_arvalid = (state == request_st);
        axi_rready  = (state == load_st);
        replace     = (state != idle_st);
    end

endmodule

`default_nettype wire

//--- source/cache_top.sv
`default_nettype none

module cache_top
#(
    parameter logic [cache_pkg::axi_id_w-1:0] axi_id = '0
)
(
    input  wire                                clk,
    input  wire                                reset,
    // front end
    input  wire                                fe_valid,
    input  wire  [cache_pkg::addr_w-1:0]       fe_addr,
    output wire  [cache_pkg::data_w-1:0]       fe_rdata,
    output wire                                fe_ready,
    // AXI read address
    output wire  [cache_pkg::addr_w-1:0]       axi_araddr,
    output wire  [7:0]                         axi_arlen,
    output wire  [2:0]                         axi_arsize,
    output wire  [1:0]                         axi_arburst,
    output wire  [0:0]                         axi_arlock,
    output wire  [3:0]                         axi_arcache,
    output wire  [2:0]                         axi_arprot,
    output wire  [3:0]                         axi_arqos,
    output wire  [cache_pkg::axi_id_w-1:0]     axi_arid,
    output wire                                axi_arvalid,
    input  wire                                axi_arready,
    // AXI read data
    input  wire                                axi_rvalid,
    input  wire  [cache_pkg::data_w-1:0]       axi_rdata,
    input  wire  [1:0]                         axi_rresp,
    input  wire                                axi_rlast,
    output wire                                axi_rready
);

    wire                              replace_valid;
    wire [cache_pkg::line_addr_w-1:0] replace_addr;
    wire                              replace;

    line_fill_if fill ();
    lookup_if    lookup ();

    cache_control cache_control_i (
        .clk           (clk),
        .reset         (reset),
        .fe_valid      (fe_valid),
        .fe_addr       (fe_addr),
        .fe_rdata      (fe_rdata),
        .fe_ready      (fe_ready),
        .replace_valid (replace_valid),
        .replace_addr  (replace_addr),
        .replace       (replace),
        .lookup        (lookup.control)
    );

    cache_memory cache_memory_i (
        .clk    (clk),
        .reset  (reset),
        .lookup (lookup.memory),
        .fill   (fill.memory)
    );

    read_channel_axi #(
        .axi_id (axi_id)
    ) read_channel_axi_i (
        .clk           (clk),
        .reset         (reset),
        .replace_valid (replace_valid),
        .replace_addr  (replace_addr),
        .replace       (replace),
        .fill          (fill.channel),
        .axi_araddr    (axi_araddr),
        .axi_arlen     (axi_arlen),
        .axi_arsize    (axi_arsize),
        .axi_arburst   (axi_arburst),
        .axi_arlock    (axi_arlock),
        .axi_arcache   (axi_arcache),
        .axi_arprot    (axi_arprot),
        .axi_arqos     (axi_arqos),
        .axi_arid      (axi_arid),
        .axi_arvalid   (axi_arvalid),
        .axi_arready   (axi_arready),
        .axi_rvalid    (axi_rvalid),
        .axi_rdata     (axi_rdata),
        .axi_rresp     (axi_rresp),
        .axi_rlast     (axi_rlast),
        .axi_rready    (axi_rready)
    );

endmodule

`default_nettype wire

//--- testbench/axi_mem_model.sv
`default_nettype none

// AXI read slave, word data is the byte address XOR data_key
module axi_mem_model
#(
    parameter logic [31:0] data_key  = 32'h0,
    parameter int          seed_init = 0
)
(
    input  wire         clk,
    input  wire         reset,
    input  wire         stall_en,   // random arready and rvalid gaps
    input  wire  [31:0] err_burst,  // burst number with one slverr beat, 0 for none
    input  wire  [31:0] araddr,
    input  wire  [7:0]  arlen,
    input  wire         arvalid,
    output logic        arready,
    output logic        rvalid,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rlast,
    input  wire         rready
);
    timeunit 1ns;
    timeprecision 1ps;

    integer      seed = seed_init;
    logic        busy;
    logic [31:0] addr_q;
    logic [7:0]  len_q;
    logic [7:0]  cnt;       // beats issued so far
    logic [31:0] burst_no;  // counts accepted bursts from 1
    logic        bad;

    always @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            arready  <= 1'b0;
            rvalid   <= 1'b0;
            rdata    <= '0;
            rresp    <= 2'b00;
            rlast    <= 1'b0;
            busy     <= 1'b0;
            addr_q   <= '0;
            len_q    <= '0;
            cnt      <= '0;
            burst_no <= '0;
        end
        else if (!busy)
        begin
            if (arvalid && arready)
            begin
                busy     <= 1'b1;
                addr_q   <= araddr;
                len_q    <= arlen;
                cnt      <= '0;
                burst_no <= burst_no + 1;
                arready  <= 1'b0;
            end
            else
            begin
                arready <= !stall_en || (($random(seed) & 1) != 0);
            end
        end
        else if (rvalid && rready && rlast)
        begin
            rvalid <= 1'b0;
            rlast  <= 1'b0;
            busy   <= 1'b0;
        end
        else if (!rvalid || rready)
        begin
            if (stall_en && (($random(seed) & 3) == 0))
            begin
                rvalid <= 1'b0;
            end
            else
            begin
                bad    = (burst_no == err_burst) && (cnt == 8'd1);  // second beat
                rvalid <= 1'b1;
                rdata  <= ((addr_q + 32'(cnt) * 4) ^ data_key) ^ {32{bad}};  // garbage on error
                rresp  <= bad ? 2'b10 : 2'b00;
                rlast  <= (cnt == len_q);
                cnt    <= cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- testbench/cache_sva.sv
`default_nettype none

module cache_sva
#(
    parameter logic [cache_pkg::axi_id_w-1:0] axi_id = '0
)
(
    input wire                            clk,
    input wire                            reset,
    input wire                            fe_ready,
    input wire [31:0]                     axi_araddr,
    input wire [7:0]                      axi_arlen,
    input wire [2:0]                      axi_arsize,
    input wire [1:0]                      axi_arburst,
    input wire [0:0]                      axi_arlock,
    input wire [3:0]                      axi_arcache,
    input wire [2:0]                      axi_arprot,
    input wire [3:0]                      axi_arqos,
    input wire [cache_pkg::axi_id_w-1:0]  axi_arid,
    input wire                            axi_arvalid,
    input wire                            axi_arready,
    input wire                            axi_rready
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    // one 4-beat incremental fetch of a whole line
    ar_fields: assert property (@(posedge clk) disable iff (reset)
        axi_arvalid |-> axi_arlen == 8'd3 && axi_arsize == 3'd2 && axi_arburst == 2'b01
                        && axi_araddr[3:0] == 4'h0 && axi_arid == axi_id
                        && axi_arlock == 1'b0 && axi_arcache == 4'b0011
                        && axi_arprot == 3'd0 && axi_arqos == 4'd0)
        else
        begin
            fail_count++;
            $error("AR fields wrong for address %h", axi_araddr);
        end

    fe_quiet: assert property (@(posedge clk) disable iff (reset)
        fe_ready |-> !axi_arvalid && !axi_rready)
        else
        begin
            fail_count++;
            $error("fe_ready high during a refill");
        end

    // request held until accepted
    ar_hold: assert property (@(posedge clk) disable iff (reset)
        axi_arvalid && !axi_arready |=> axi_arvalid && $stable(axi_araddr))
        else
        begin
            fail_count++;
            $error("AR request dropped or changed before arready");
        end

    reset_quiet: assert property (@(posedge clk)
        $fell(reset) |-> !fe_ready && !axi_arvalid && !axi_rready)
        else
        begin
            fail_count++;
            $error("control outputs not low after reset");
        end

endmodule

bind cache_top cache_sva #(.axi_id(axi_id)) cache_sva_i (
    .clk         (clk),
    .reset       (reset),
    .fe_ready    (fe_ready),
    .axi_araddr  (axi_araddr),
    .axi_arlen   (axi_arlen),
    .axi_arsize  (axi_arsize),
    .axi_arburst (axi_arburst),
    .axi_arlock  (axi_arlock),
    .axi_arcache (axi_arcache),
    .axi_arprot  (axi_arprot),
    .axi_arqos   (axi_arqos),
    .axi_arid    (axi_arid),
    .axi_arvalid (axi_arvalid),
    .axi_arready (axi_arready),
    .axi_rready  (axi_rready)
);

`default_nettype wire

//--- testbench/tb_cache_top.sv
`default_nettype none

module tb_cache_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [0:0]  axi_id         = 1'b1;
    localparam logic [31:0] data_key       = 32'h5a5a_c3c3;
    localparam int          timeout_cycles = 500;

    logic        clk;
    logic        reset;
    logic        fe_valid;
    logic [31:0] fe_addr;
    logic [31:0] fe_rdata;
    logic        fe_ready;
    logic [31:0] axi_araddr;
    logic [7:0]  axi_arlen;
    logic [2:0]  axi_arsize;
    logic [1:0]  axi_arburst;
    logic [0:0]  axi_arlock;
    logic [3:0]  axi_arcache;
    logic [2:0]  axi_arprot;
    logic [3:0]  axi_arqos;
    logic [0:0]  axi_arid;
    logic        axi_arvalid;
    logic        axi_arready;
    logic        axi_rvalid;
    logic [31:0] axi_rdata;
    logic [1:0]  axi_rresp;
    logic        axi_rlast;
    logic        axi_rready;
    logic        stall_en;
    logic [31:0] err_burst;
    integer      seed = 32'ha26b_edb8;
    int          errors = 0;
    int          ar_count = 0;
    logic [31:0] ar_addr_q [$];
    logic [23:0] ref_tag [16];  // reference copy of the tag store
    logic        ref_valid [16];
    logic [31:0] rnd;

    cache_top #(.axi_id(axi_id)) cache_top_i (.*);

    axi_mem_model #(.data_key(data_key), .seed_init(32'ha26b_edb8)) axi_mem_model_i (
        .clk (clk), .reset (reset), .stall_en (stall_en), .err_burst (err_burst),
        .araddr (axi_araddr), .arlen (axi_arlen), .arvalid (axi_arvalid),
        .arready (axi_arready), .rvalid (axi_rvalid), .rdata (axi_rdata),
        .rresp (axi_rresp), .rlast (axi_rlast), .rready (axi_rready)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk)
    begin
        if (!reset && axi_arvalid && axi_arready)
        begin
            ar_count++;
            ar_addr_q.push_back(axi_araddr);
        end
    end

    task automatic count_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] expected);
        errors++;
        $display("mismatch at %0t: %s got %h expected %h", $time, name, got, expected);
    endtask

    task automatic finish_run();
        int sva_fails;
        sva_fails = cache_top_i.cache_sva_i.fail_count;
        $display("check errors: %0d, assertion failures: %0d", errors, sva_fails);
        if (errors == 0 && sva_fails == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    endtask

    task automatic stop_on_timeout(input string what);
        errors++;
        $display("timeout after %0d cycles: %s", timeout_cycles, what);
        finish_run();
    endtask

    // one front-end read, a retry adds a second AR for the same line
    task automatic access(input logic [31:0] addr, input bit retry);
        int          cycles;
        int          ar_start;
        int          exp_ars;
        logic [31:0] got;
        exp_ars  = (ref_valid[addr[7:4]] && ref_tag[addr[7:4]] == addr[31:8]) ? 0 : 1;
        exp_ars  = exp_ars + (retry ? 1 : 0);
        ar_start = ar_count;
        @(posedge clk);
        fe_valid <= 1'b1;
        fe_addr  <= addr;
        cycles = 0;
        @(negedge clk);
        while (!fe_ready && cycles < timeout_cycles)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!fe_ready)
            stop_on_timeout("fe_ready never came for the front-end request");
        assert (fe_rdata == ({addr[31:2], 2'b00} ^ data_key))
            else count_mismatch("fe_rdata", fe_rdata, {addr[31:2], 2'b00} ^ data_key);
        assert (ar_count - ar_start == exp_ars)
            else count_mismatch("AR handshake count", ar_count - ar_start, exp_ars);
        while (ar_addr_q.size() > 0)
        begin
            got = ar_addr_q.pop_front();
            assert (got == {addr[31:4], 4'h0})
                else count_mismatch("axi_araddr", got, {addr[31:4], 4'h0});
        end
        @(posedge clk);
        fe_valid <= 1'b0;
        ref_valid[addr[7:4]] = 1'b1;
        ref_tag[addr[7:4]]   = addr[31:8];
    endtask

    initial
    begin
        reset     = 1'b1;
        fe_valid  = 1'b0;
        fe_addr   = '0;
        stall_en  = 1'b0;
        err_burst = '0;
        for (int i = 0; i < 16; i++)
            ref_valid[i] = 1'b0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        access(32'h0000_1040, 1'b0);  // cold miss
        for (int w = 0; w < 4; w++)
            access(32'h0000_1040 + w * 4, 1'b0);
        for (int k = 0; k < 4; k++)
        begin
            rnd = $random(seed);
            access({28'h0000_104, rnd[3:2], 2'b00}, 1'b0);
        end

        access(32'h0001_1048, 1'b0);  // same index, other tag
        access(32'h0000_1048, 1'b0);

        @(posedge clk);
        err_burst <= ar_count + 1;  // slverr on the next burst
        access(32'h0000_2294, 1'b1);
        @(posedge clk);
        err_burst <= '0;
        access(32'h0000_2294, 1'b0);

        @(posedge clk);
        stall_en <= 1'b1;
        for (int k = 0; k < 12; k++)
        begin
            rnd = $random(seed);
            access({22'h0, rnd[9:8], rnd[7:2], 2'b00}, 1'b0);
        end

        repeat (4) @(posedge clk);
        finish_run();
    end

endmodule

`default_nettype wire

//--- cache_axi_read.f
source/cache_pkg.sv
source/cache_if.sv
source/cache_control.sv
source/cache_memory.sv
source/read_channel_axi.sv
source/cache_top.sv
testbench/axi_mem_model.sv
testbench/cache_sva.sv
testbench/tb_cache_top.sv
